// File: design/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// joint tlb size
`define TLB_ENTRIES 8
`define TLB_IDX_W   3

// 4 KB pages only, so a 20-bit frame number
`define PFN_W       20

`define ASID_W      8

`endif

// File: design/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // top 3 bits pick kuseg/kseg0/kseg1/...
    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] off;
    } seg_view_t;

    // even/odd page pair per tlb entry
    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] off;
    } page_view_t;

    typedef union packed {
        seg_view_t  seg;
        page_view_t page;
    } vaddr_u;

    typedef enum logic [1:0] {
        TLB_PROBE      = 2'd0,
        TLB_READ       = 2'd1,
        TLB_WRITE_IDX  = 2'd2,
        TLB_WRITE_RAND = 2'd3
    } tlb_op_e;

endpackage

`default_nettype wire

// File: design/tlb_op_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_op_decode (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_instr_valid,
    input  logic [31:0]       i_instr,
    output logic              o_op_valid,
    output mmu_pkg::tlb_op_e  o_op
);

    logic             is_cop0_co;
    logic             func_hit;
    mmu_pkg::tlb_op_e dec_op;

    // COP0 opcode with the CO bit set
    assign is_cop0_co = (i_instr[31:26] == 6'b010000) && i_instr[25];

    always_comb begin
        func_hit = 1'b1;
        dec_op   = mmu_pkg::TLB_PROBE;
        case (i_instr[5:0])
            6'h08: dec_op = mmu_pkg::TLB_PROBE;
            6'h01: dec_op = mmu_pkg::TLB_READ;
            6'h02: dec_op = mmu_pkg::TLB_WRITE_IDX;
            6'h06: dec_op = mmu_pkg::TLB_WRITE_RAND;
            default: func_hit = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_op_valid <= 1'b0;
        end else begin
            o_op_valid <= i_instr_valid && is_cop0_co && func_hit;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            o_op <= dec_op;
        end
    end

    // back-to-back ops need back-to-back instructions
    a_op_pulse: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_op_valid && $past(o_op_valid) |-> $past(i_instr_valid)
    );

endmodule

`default_nettype wire

// File: design/tlb_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module tlb_array (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_op_valid,
    input  mmu_pkg::tlb_op_e      i_op,
    input  logic [31:0]           i_entryhi,
    input  logic [31:0]           i_entrylo0,
    input  logic [31:0]           i_entrylo1,
    input  logic [`TLB_IDX_W-1:0] i_index,
    input  logic [`TLB_IDX_W-1:0] i_random,
    input  logic [31:0]           i_inst_vaddr,
    input  logic [31:0]           i_data_vaddr,
    output logic                  o_inst_hit,
    output logic                  o_data_hit,
    output logic [`PFN_W-1:0]     o_inst_pfn,
    output logic [`PFN_W-1:0]     o_data_pfn,
    output logic [2:0]            o_inst_c,
    output logic [2:0]            o_data_c,
    output logic                  o_inst_v,
    output logic                  o_data_v,
    output logic                  o_data_d,
    output logic                  o_probe_hit,
    output logic [`TLB_IDX_W-1:0] o_probe_idx,
    output logic [31:0]           o_rd_entryhi,
    output logic [31:0]           o_rd_entrylo0,
    output logic [31:0]           o_rd_entrylo1
);

    logic [18:0]         vpn2 [`TLB_ENTRIES];
    logic [`ASID_W-1:0]  asid [`TLB_ENTRIES];
    logic                g    [`TLB_ENTRIES];
    logic [`PFN_W-1:0]   pfn0 [`TLB_ENTRIES];
    logic [`PFN_W-1:0]   pfn1 [`TLB_ENTRIES];
    logic [2:0]          c0   [`TLB_ENTRIES];
    logic [2:0]          c1   [`TLB_ENTRIES];
    logic                d0   [`TLB_ENTRIES];
    logic                d1   [`TLB_ENTRIES];
    logic                v0   [`TLB_ENTRIES];
    logic                v1   [`TLB_ENTRIES];

    logic [`TLB_ENTRIES-1:0] probe_match;
    logic [`TLB_ENTRIES-1:0] inst_match;
    logic [`TLB_ENTRIES-1:0] data_match;
    logic [`TLB_ENTRIES-1:0] live;
    logic                    wr_en;
    logic [`TLB_IDX_W-1:0]   wr_idx;
    mmu_pkg::vaddr_u         inst_va;
    mmu_pkg::vaddr_u         data_va;

    // global entries ignore the asid
    function automatic logic [`TLB_ENTRIES-1:0] match_vec(
        input logic [18:0]        tag,
        input logic [`ASID_W-1:0] id
    );
        logic [`TLB_ENTRIES-1:0] m;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            m[i] = (vpn2[i] == tag) && (g[i] || (asid[i] == id));
        end
        return m;
    endfunction

    assign inst_va = i_inst_vaddr;
    assign data_va = i_data_vaddr;

    assign wr_en  = i_op_valid && ((i_op == mmu_pkg::TLB_WRITE_IDX) ||
                                   (i_op == mmu_pkg::TLB_WRITE_RAND));
    assign wr_idx = (i_op == mmu_pkg::TLB_WRITE_RAND) ? i_random : i_index;

    // tag and valid bits decide matching, so they are cleared
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                vpn2[i] <= '0;
                asid[i] <= '0;
                g[i]    <= 1'b0;
                v0[i]   <= 1'b0;
                v1[i]   <= 1'b0;
            end
        end else if (wr_en) begin
            vpn2[wr_idx] <= i_entryhi[31:13];
            asid[wr_idx] <= i_entryhi[`ASID_W-1:0];
            g[wr_idx]    <= i_entrylo0[0] & i_entrylo1[0];
            v0[wr_idx]   <= i_entrylo0[1];
            v1[wr_idx]   <= i_entrylo1[1];
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            pfn0[wr_idx] <= i_entrylo0[25:6];
            c0[wr_idx]   <= i_entrylo0[5:3];
            d0[wr_idx]   <= i_entrylo0[2];
            pfn1[wr_idx] <= i_entrylo1[25:6];
            c1[wr_idx]   <= i_entrylo1[5:3];
            d1[wr_idx]   <= i_entrylo1[2];
        end
    end

    assign probe_match = match_vec(i_entryhi[31:13], i_entryhi[`ASID_W-1:0]);
    assign inst_match  = match_vec(inst_va.page.vpn2, i_entryhi[`ASID_W-1:0]);
    assign data_match  = match_vec(data_va.page.vpn2, i_entryhi[`ASID_W-1:0]);

    assign o_probe_hit = |probe_match;
    assign o_inst_hit  = |inst_match;
    assign o_data_hit  = |data_match;

    always_comb begin
        o_probe_idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (probe_match[i]) begin
                o_probe_idx = `TLB_IDX_W'(i);
            end
        end
    end

    // odd bit picks the half of the pair
    always_comb begin
        o_inst_pfn = '0;
        o_inst_c   = '0;
        o_inst_v   = 1'b0;
        o_data_pfn = '0;
        o_data_c   = '0;
        o_data_v   = 1'b0;
        o_data_d   = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (inst_match[i]) begin
                o_inst_pfn = inst_va.page.odd ? pfn1[i] : pfn0[i];
                o_inst_c   = inst_va.page.odd ? c1[i] : c0[i];
                o_inst_v   = inst_va.page.odd ? v1[i] : v0[i];
            end
            if (data_match[i]) begin
                o_data_pfn = data_va.page.odd ? pfn1[i] : pfn0[i];
                o_data_c   = data_va.page.odd ? c1[i] : c0[i];
                o_data_v   = data_va.page.odd ? v1[i] : v0[i];
                o_data_d   = data_va.page.odd ? d1[i] : d0[i];
            end
            live[i] = v0[i] | v1[i];
        end
    end

    // TLBR words in CP0 layout
    assign o_rd_entryhi  = {vpn2[i_index], {(13 - `ASID_W){1'b0}}, asid[i_index]};
    assign o_rd_entrylo0 = {{(26 - `PFN_W){1'b0}}, pfn0[i_index], c0[i_index],
                            d0[i_index], v0[i_index], g[i_index]};
    assign o_rd_entrylo1 = {{(26 - `PFN_W){1'b0}}, pfn1[i_index], c1[i_index],
                            d1[i_index], v1[i_index], g[i_index]};

    // software must never load duplicate live entries
    a_single_match: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot0(inst_match & live) && $onehot0(data_match & live)
    );

endmodule

`default_nettype wire

// File: design/tlb_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module tlb_result (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_op_valid,
    input  mmu_pkg::tlb_op_e      i_op,
    input  logic                  i_inst_en,
    input  logic                  i_data_read,
    input  logic                  i_data_write,
    input  logic [31:0]           i_inst_vaddr,
    input  logic [31:0]           i_data_vaddr,
    input  logic                  i_inst_hit,
    input  logic                  i_data_hit,
    input  logic [`PFN_W-1:0]     i_inst_pfn,
    input  logic [`PFN_W-1:0]     i_data_pfn,
    input  logic [2:0]            i_inst_c,
    input  logic [2:0]            i_data_c,
    input  logic                  i_inst_v,
    input  logic                  i_data_v,
    input  logic                  i_data_d,
    input  logic                  i_probe_hit,
    input  logic [`TLB_IDX_W-1:0] i_probe_idx,
    input  logic [31:0]           i_rd_entryhi,
    input  logic [31:0]           i_rd_entrylo0,
    input  logic [31:0]           i_rd_entrylo1,
    output logic                  o_inst_valid,
    output logic                  o_inst_uncached,
    output logic                  o_inst_refill,
    output logic                  o_inst_invalid,
    output logic [`PFN_W-1:0]     o_inst_pfn,
    output logic                  o_data_valid,
    output logic                  o_data_uncached,
    output logic                  o_data_refill,
    output logic                  o_data_invalid,
    output logic                  o_data_modify,
    output logic [`PFN_W-1:0]     o_data_pfn,
    output logic                  o_entry_wen,
    output logic                  o_index_wen,
    output logic [31:0]           o_entryhi,
    output logic [31:0]           o_entrylo0,
    output logic [31:0]           o_entrylo1,
    output logic [31:0]           o_index
);

    mmu_pkg::vaddr_u   inst_va;
    mmu_pkg::vaddr_u   data_va;
    logic              inst_mapped, data_mapped;
    logic              inst_refill, inst_invalid;
    logic              data_refill, data_invalid, data_modify;
    logic              data_en;
    logic [`PFN_W-1:0] inst_pfn, data_pfn;
    logic              inst_uncached, data_uncached;

    assign inst_va = i_inst_vaddr;
    assign data_va = i_data_vaddr;
    assign data_en = i_data_read | i_data_write;

    // kseg0 = 3'b100, kseg1 = 3'b101
    assign inst_mapped = (inst_va.seg.seg[2:1] != 2'b10);
    assign data_mapped = (data_va.seg.seg[2:1] != 2'b10);

    // refill over invalid over modify
    assign inst_refill  = inst_mapped & ~i_inst_hit;
    assign inst_invalid = inst_mapped & i_inst_hit & ~i_inst_v;
    assign data_refill  = data_mapped & ~i_data_hit;
    assign data_invalid = data_mapped & i_data_hit & ~i_data_v;
    assign data_modify  = data_mapped & i_data_hit & i_data_v & ~i_data_d & i_data_write;

    always_comb begin
        if (inst_refill | inst_invalid) begin
            inst_pfn = '0;
        end else if (inst_mapped) begin
            inst_pfn = i_inst_pfn;
        end else begin
            inst_pfn = {3'b000, inst_va.seg.off[28:12]};
        end
        if (data_refill | data_invalid | data_modify) begin
            data_pfn = '0;
        end else if (data_mapped) begin
            data_pfn = i_data_pfn;
        end else begin
            data_pfn = {3'b000, data_va.seg.off[28:12]};
        end
    end

    assign inst_uncached = inst_mapped ? (i_inst_c == 3'd2) : inst_va.seg.seg[0];
    assign data_uncached = data_mapped ? (i_data_c == 3'd2) : data_va.seg.seg[0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_inst_valid   <= 1'b0;
            o_inst_refill  <= 1'b0;
            o_inst_invalid <= 1'b0;
            o_data_valid   <= 1'b0;
            o_data_refill  <= 1'b0;
            o_data_invalid <= 1'b0;
            o_data_modify  <= 1'b0;
            o_entry_wen    <= 1'b0;
            o_index_wen    <= 1'b0;
        end else begin
            o_inst_valid   <= i_inst_en;
            o_inst_refill  <= i_inst_en & inst_refill;
            o_inst_invalid <= i_inst_en & inst_invalid;
            o_data_valid   <= data_en;
            o_data_refill  <= data_en & data_refill;
            o_data_invalid <= data_en & data_invalid;
            o_data_modify  <= data_en & data_modify;
            o_entry_wen    <= i_op_valid && (i_op == mmu_pkg::TLB_READ);
            o_index_wen    <= i_op_valid && (i_op == mmu_pkg::TLB_PROBE);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_inst_en) begin
            o_inst_pfn      <= inst_pfn;
            o_inst_uncached <= inst_uncached;
        end
        if (data_en) begin
            o_data_pfn      <= data_pfn;
            o_data_uncached <= data_uncached;
        end
        if (i_op_valid && (i_op == mmu_pkg::TLB_READ)) begin
            o_entryhi  <= i_rd_entryhi;
            o_entrylo0 <= i_rd_entrylo0;
            o_entrylo1 <= i_rd_entrylo1;
        end
        // probe miss sets P and reports index zero
        if (i_op_valid && (i_op == mmu_pkg::TLB_PROBE)) begin
            o_index <= {~i_probe_hit, {(31 - `TLB_IDX_W){1'b0}},
                        {`TLB_IDX_W{i_probe_hit}} & i_probe_idx};
        end
    end

    a_one_data_exc: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $onehot0({o_data_refill, o_data_invalid, o_data_modify})
    );

endmodule

`default_nettype wire

// File: design/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_top (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_instr_valid,
    input  logic [31:0]           i_instr,
    input  logic [31:0]           i_entryhi,
    input  logic [31:0]           i_entrylo0,
    input  logic [31:0]           i_entrylo1,
    input  logic [`TLB_IDX_W-1:0] i_index,
    input  logic [`TLB_IDX_W-1:0] i_random,
    input  logic                  i_inst_en,
    input  logic [31:0]           i_inst_vaddr,
    input  logic                  i_data_read,
    input  logic                  i_data_write,
    input  logic [31:0]           i_data_vaddr,
    output logic                  o_inst_valid,
    output logic                  o_inst_uncached,
    output logic                  o_inst_refill,
    output logic                  o_inst_invalid,
    output logic [`PFN_W-1:0]     o_inst_pfn,
    output logic                  o_data_valid,
    output logic                  o_data_uncached,
    output logic                  o_data_refill,
    output logic                  o_data_invalid,
    output logic                  o_data_modify,
    output logic [`PFN_W-1:0]     o_data_pfn,
    output logic                  o_entry_wen,
    output logic                  o_index_wen,
    output logic [31:0]           o_entryhi,
    output logic [31:0]           o_entrylo0,
    output logic [31:0]           o_entrylo1,
    output logic [31:0]           o_index
);

    logic                  op_valid;
    mmu_pkg::tlb_op_e      op;
    logic                  inst_hit, data_hit;
    logic [`PFN_W-1:0]     inst_pfn, data_pfn;
    logic [2:0]            inst_c, data_c;
    logic                  inst_v, data_v, data_d;
    logic                  probe_hit;
    logic [`TLB_IDX_W-1:0] probe_idx;
    logic [31:0]           rd_entryhi, rd_entrylo0, rd_entrylo1;

    tlb_op_decode decode0 (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_instr_valid(i_instr_valid), .i_instr(i_instr),
        .o_op_valid(op_valid), .o_op(op)
    );

    tlb_array array0 (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_op_valid(op_valid), .i_op(op),
        .i_entryhi(i_entryhi), .i_entrylo0(i_entrylo0), .i_entrylo1(i_entrylo1),
        .i_index(i_index), .i_random(i_random),
        .i_inst_vaddr(i_inst_vaddr), .i_data_vaddr(i_data_vaddr),
        .o_inst_hit(inst_hit), .o_data_hit(data_hit),
        .o_inst_pfn(inst_pfn), .o_data_pfn(data_pfn),
        .o_inst_c(inst_c), .o_data_c(data_c),
        .o_inst_v(inst_v), .o_data_v(data_v), .o_data_d(data_d),
        .o_probe_hit(probe_hit), .o_probe_idx(probe_idx),
        .o_rd_entryhi(rd_entryhi), .o_rd_entrylo0(rd_entrylo0),
        .o_rd_entrylo1(rd_entrylo1)
    );

    tlb_result result0 (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_op_valid(op_valid), .i_op(op),
        .i_inst_en(i_inst_en), .i_data_read(i_data_read), .i_data_write(i_data_write),
        .i_inst_vaddr(i_inst_vaddr), .i_data_vaddr(i_data_vaddr),
        .i_inst_hit(inst_hit), .i_data_hit(data_hit),
        .i_inst_pfn(inst_pfn), .i_data_pfn(data_pfn),
        .i_inst_c(inst_c), .i_data_c(data_c),
        .i_inst_v(inst_v), .i_data_v(data_v), .i_data_d(data_d),
        .i_probe_hit(probe_hit), .i_probe_idx(probe_idx),
        .i_rd_entryhi(rd_entryhi), .i_rd_entrylo0(rd_entrylo0),
        .i_rd_entrylo1(rd_entrylo1),
        .o_inst_valid(o_inst_valid), .o_inst_uncached(o_inst_uncached),
        .o_inst_refill(o_inst_refill), .o_inst_invalid(o_inst_invalid),
        .o_inst_pfn(o_inst_pfn),
        .o_data_valid(o_data_valid), .o_data_uncached(o_data_uncached),
        .o_data_refill(o_data_refill), .o_data_invalid(o_data_invalid),
        .o_data_modify(o_data_modify), .o_data_pfn(o_data_pfn),
        .o_entry_wen(o_entry_wen), .o_index_wen(o_index_wen),
        .o_entryhi(o_entryhi), .o_entrylo0(o_entrylo0), .o_entrylo1(o_entrylo1),
        .o_index(o_index)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_reset
);

    // 100 ns period
    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (8) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: bench/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_tb;

    localparam logic [5:0] func_tlbp  = 6'h08;
    localparam logic [5:0] func_tlbr  = 6'h01;
    localparam logic [5:0] func_tlbwi = 6'h02;
    localparam logic [5:0] func_tlbwr = 6'h06;

    logic                  clk, reset;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic [31:0]           entryhi, entrylo0, entrylo1;
    logic [`TLB_IDX_W-1:0] tlb_index, tlb_random;
    logic                  inst_en, data_read, data_write;
    logic [31:0]           inst_vaddr, data_vaddr;
    logic                  inst_valid, inst_uncached, inst_refill, inst_invalid;
    logic [`PFN_W-1:0]     inst_pfn;
    logic                  data_valid, data_uncached, data_refill, data_invalid, data_modify;
    logic [`PFN_W-1:0]     data_pfn;
    logic                  entry_wen, index_wen;
    logic [31:0]           rd_entryhi, rd_entrylo0, rd_entrylo1, index_word;

    // reference tlb, lo words keep pfn/c/d/v with g held apart
    logic [31:0] mdl_hi  [`TLB_ENTRIES];
    logic [31:0] mdl_lo0 [`TLB_ENTRIES];
    logic [31:0] mdl_lo1 [`TLB_ENTRIES];
    logic        mdl_g   [`TLB_ENTRIES];

    logic [31:0] seed;
    int          checks, value_errors, other_errors;

    tb_clock clock0 (.o_clk(clk), .o_reset(reset));

    mmu_top dut0 (
        .i_clk(clk), .i_reset(reset),
        .i_instr_valid(instr_valid), .i_instr(instr),
        .i_entryhi(entryhi), .i_entrylo0(entrylo0), .i_entrylo1(entrylo1),
        .i_index(tlb_index), .i_random(tlb_random),
        .i_inst_en(inst_en), .i_inst_vaddr(inst_vaddr),
        .i_data_read(data_read), .i_data_write(data_write), .i_data_vaddr(data_vaddr),
        .o_inst_valid(inst_valid), .o_inst_uncached(inst_uncached),
        .o_inst_refill(inst_refill), .o_inst_invalid(inst_invalid), .o_inst_pfn(inst_pfn),
        .o_data_valid(data_valid), .o_data_uncached(data_uncached),
        .o_data_refill(data_refill), .o_data_invalid(data_invalid),
        .o_data_modify(data_modify), .o_data_pfn(data_pfn),
        .o_entry_wen(entry_wen), .o_index_wen(index_wen),
        .o_entryhi(rd_entryhi), .o_entrylo0(rd_entrylo0), .o_entrylo1(rd_entrylo1),
        .o_index(index_word)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 15);
    endfunction

    function automatic logic [31:0] cop0_word(input logic [5:0] func);
        return {6'b010000, 1'b1, 19'd0, func};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("error: time %0t, %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("failure at time %0t: %s", $time, what);
    endtask

    // mips rules: kseg0/kseg1 bypass, then refill, invalid, modify
    function automatic void predict(
        input  logic [31:0]       va,
        input  logic [7:0]        asid,
        input  logic              is_write,
        output logic              refill,
        output logic              invalid,
        output logic              modify,
        output logic              uncached,
        output logic [`PFN_W-1:0] pfn
    );
        logic        hit;
        logic [31:0] lo;
        hit      = 1'b0;
        lo       = '0;
        refill   = 1'b0;
        invalid  = 1'b0;
        modify   = 1'b0;
        uncached = 1'b0;
        pfn      = '0;
        if (va[31:30] == 2'b10) begin
            pfn      = {3'b000, va[28:12]};
            uncached = va[29];
        end else begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (!hit && mdl_hi[i][31:13] == va[31:13] &&
                    (mdl_g[i] || mdl_hi[i][7:0] == asid)) begin
                    hit = 1'b1;
                    lo  = va[12] ? mdl_lo1[i] : mdl_lo0[i];
                end
            end
            uncached = (lo[5:3] == 3'd2);
            if (!hit) begin
                refill = 1'b1;
            end else if (!lo[1]) begin
                invalid = 1'b1;
            end else if (is_write && !lo[2]) begin
                modify = 1'b1;
            end else begin
                pfn = lo[25:6];
            end
        end
    endfunction

    task automatic issue_instr(input logic [31:0] word);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic wait_writeback(input logic want_index, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < 8 && !seen; n++) begin
            @(negedge clk);
            seen = want_index ? index_wen : entry_wen;
        end
        assert (seen) else begin
            report_failure("no write-back strobe within 8 cycles of a TLB instruction");
        end
    endtask

    task automatic end_of_pulse();
        @(negedge clk);
        assert (!entry_wen && !index_wen) else begin
            report_failure("write-back strobe held for more than one cycle");
        end
    endtask

    task automatic read_back(input logic [2:0] idx);
        logic seen;
        @(posedge clk);
        tlb_index <= idx;
        issue_instr(cop0_word(func_tlbr));
        wait_writeback(1'b0, seen);
        if (seen) begin
            check_word("o_entryhi", rd_entryhi, mdl_hi[idx]);
            check_word("o_entrylo0", rd_entrylo0, mdl_lo0[idx] | 32'(mdl_g[idx]));
            check_word("o_entrylo1", rd_entrylo1, mdl_lo1[idx] | 32'(mdl_g[idx]));
            end_of_pulse();
        end
    endtask

    task automatic write_entry(input logic use_random, input logic [2:0] idx);
        logic [31:0] r, r2, hi, lo0, lo1;
        logic [18:0] vpn2;
        logic        g0, g1;
        r  = next_rand();
        r2 = next_rand();
        // low tag bits follow the index, so no two entries share a tag
        vpn2 = {r[31:16] | 16'h0001, idx};
        if (vpn2[18:17] == 2'b10) begin
            vpn2[18] = 1'b0;
        end
        hi  = {vpn2, 5'd0, r2[7:0]};
        lo0 = next_rand() & 32'h03ff_fffe;
        lo1 = next_rand() & 32'h03ff_fffe;
        // mostly valid pages
        lo0[1] = lo0[1] | r2[8];
        lo1[1] = lo1[1] | r2[9];
        g0 = (r2[10] & r2[11]) | r2[12];
        g1 = (r2[10] & r2[11]) | r2[13];
        @(posedge clk);
        entryhi  <= hi;
        entrylo0 <= lo0 | 32'(g0);
        entrylo1 <= lo1 | 32'(g1);
        tlb_index  <= use_random ? r2[18:16] : idx;
        tlb_random <= use_random ? idx : r2[18:16];
        issue_instr(cop0_word(use_random ? func_tlbwr : func_tlbwi));
        // entry lands two edges after the instruction is sampled
        repeat (2) @(posedge clk);
        mdl_hi[idx]  = hi;
        mdl_lo0[idx] = lo0;
        mdl_lo1[idx] = lo1;
        mdl_g[idx]   = g0 & g1;
        read_back(idx);
    endtask

    task automatic ignore_check(input logic [2:0] idx);
        logic [31:0] word;
        logic        strobe;
        word = next_rand();
        if (word[31:25] == 7'b0100001) begin
            word[25] = 1'b0;
        end
        // eret has the CO bit but is not a TLB function
        if (word[3]) begin
            word = cop0_word(6'h18);
        end
        // a stray write would replace the entry with these words
        @(posedge clk);
        entryhi    <= ~mdl_hi[idx];
        entrylo0   <= ~mdl_lo0[idx];
        entrylo1   <= ~mdl_lo1[idx];
        tlb_index  <= idx;
        tlb_random <= idx;
        issue_instr(word);
        strobe = 1'b0;
        repeat (4) begin
            @(negedge clk);
            strobe = strobe | entry_wen | index_wen;
        end
        assert (!strobe) else begin
            report_failure("write-back strobe after a non-TLB instruction");
        end
    endtask

    task automatic probe_check(input logic [31:0] hi);
        logic        seen;
        logic [31:0] expect_idx;
        expect_idx = 32'h8000_0000;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (mdl_hi[i][31:13] == hi[31:13] && (mdl_g[i] || mdl_hi[i][7:0] == hi[7:0])) begin
                expect_idx = 32'(i);
            end
        end
        @(posedge clk);
        entryhi <= hi;
        issue_instr(cop0_word(func_tlbp));
        wait_writeback(1'b1, seen);
        if (seen) begin
            check_word("o_index", index_word, expect_idx);
            end_of_pulse();
        end
    endtask

    task automatic lookup_check(input logic use_inst, input logic [31:0] iva,
                                input logic [1:0] data_op, input logic [31:0] dva,
                                input logic [7:0] asid);
        logic [`PFN_W-1:0] ipfn, dpfn;
        logic              irf, iinv, imd, iunc, drf, dinv, dmd, dunc, den;
        predict(iva, asid, 1'b0, irf, iinv, imd, iunc, ipfn);
        predict(dva, asid, data_op[1], drf, dinv, dmd, dunc, dpfn);
        den = |data_op;
        @(posedge clk);
        entryhi    <= {entryhi[31:8], asid};
        inst_en    <= use_inst;
        inst_vaddr <= iva;
        data_read  <= data_op[0];
        data_write <= data_op[1];
        data_vaddr <= dva;
        @(posedge clk);
        inst_en    <= 1'b0;
        data_read  <= 1'b0;
        data_write <= 1'b0;
        @(negedge clk);
        check_word("o_inst_valid", 32'(inst_valid), 32'(use_inst));
        check_word("o_inst_refill", 32'(inst_refill), 32'(use_inst & irf));
        check_word("o_inst_invalid", 32'(inst_invalid), 32'(use_inst & iinv));
        if (use_inst) begin
            check_word("o_inst_pfn", 32'(inst_pfn), 32'(ipfn));
            if (!irf && !iinv) begin
                check_word("o_inst_uncached", 32'(inst_uncached), 32'(iunc));
            end
        end
        check_word("o_data_valid", 32'(data_valid), 32'(den));
        check_word("o_data_refill", 32'(data_refill), 32'(den & drf));
        check_word("o_data_invalid", 32'(data_invalid), 32'(den & dinv));
        check_word("o_data_modify", 32'(data_modify), 32'(den & dmd));
        if (den) begin
            check_word("o_data_pfn", 32'(data_pfn), 32'(dpfn));
            if (!drf && !dinv && !dmd) begin
                check_word("o_data_uncached", 32'(data_uncached), 32'(dunc));
            end
        end
    endtask

    initial begin
        logic [31:0] r, va, vb;
        logic [2:0]  k;
        logic [7:0]  asid;
        logic [1:0]  dop;
        logic        done;
        seed         = 32'h8664_be8b;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        instr_valid  = 1'b0;
        instr        = '0;
        entryhi      = '0;
        entrylo0     = '0;
        entrylo1     = '0;
        tlb_index    = '0;
        tlb_random   = '0;
        inst_en      = 1'b0;
        inst_vaddr   = '0;
        data_read    = 1'b0;
        data_write   = 1'b0;
        data_vaddr   = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            mdl_hi[i]  = '0;
            mdl_lo0[i] = '0;
            mdl_lo1[i] = '0;
            mdl_g[i]   = 1'b0;
        end

        done = 1'b0;
        for (int n = 0; n < 20 && !done; n++) begin
            @(negedge clk);
            done = !reset;
        end
        assert (done) else report_failure("reset was never released");

        @(negedge clk);
        check_word("valid, exception and write-back outputs",
                   32'({inst_valid, inst_refill, inst_invalid, data_valid, data_refill,
                        data_invalid, data_modify, entry_wen, index_wen}), 32'd0);
        // empty tlb, mapped address with a nonzero tag
        for (int n = 0; n < 4; n++) begin
            va = next_rand();
            vb = next_rand();
            va[31] = 1'b0;
            va[20] = 1'b1;
            vb[31] = 1'b0;
            vb[20] = 1'b1;
            lookup_check(1'b1, va, 2'b01, vb, va[7:0]);
        end

        // first eight writes fill every entry
        for (int n = 0; n < 24; n++) begin
            r = next_rand();
            k = (n < 8) ? n[2:0] : r[2:0];
            write_entry(n >= 8 && r[3], k);
            if (n % 4 == 3) begin
                ignore_check(k);
                read_back(k);
            end
        end

        for (int n = 0; n < 16; n++) begin
            r = next_rand();
            k = r[2:0];
            if (r[3]) begin
                va = mdl_hi[k];
            end else begin
                va = next_rand();
                va[20] = 1'b1;
            end
            if (r[4]) begin
                va[7:0] = r[15:8];
            end
            probe_check(va);
        end

        for (int n = 0; n < 80; n++) begin
            r    = next_rand();
            k    = r[2:0];
            asid = r[3] ? mdl_hi[k][7:0] : r[31:24];
            va   = next_rand();
            vb   = next_rand();
            if (r[4]) begin
                va[31:13] = mdl_hi[k][31:13];
            end
            if (r[5]) begin
                vb[31:13] = mdl_hi[r[10:8]][31:13];
            end
            dop = (r[7:6] == 2'b11) ? 2'b10 : r[7:6];
            lookup_check(r[11] | r[12], va, dop, vb, asid);
        end

        // kseg0 and kseg1 only
        for (int n = 0; n < 16; n++) begin
            r  = next_rand();
            va = next_rand();
            vb = next_rand();
            va[31:30] = 2'b10;
            vb[31:30] = 2'b10;
            dop = r[0] ? 2'b10 : 2'b01;
            lookup_check(1'b1, va, dop, vb, r[15:8]);
        end

        repeat (2) @(posedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mmu.f
+incdir+design
design/mmu_pkg.sv
design/tlb_op_decode.sv
design/tlb_array.sv
design/tlb_result.sv
design/mmu_top.sv
bench/tb_clock.sv
bench/mmu_tb.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = mmu_tb
FLIST = mmu.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)

# pass only if the log holds the pass line
run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
